//--- common/daq_settings.svh
`ifndef DAQ_SETTINGS_SVH
`define DAQ_SETTINGS_SVH

// buffer depth in 32-bit slots, power of two up to 2**16
`define DAQ_FIFO_DEPTH 16

// reset values of the threshold bytes, in percent
`define DAQ_ALMOST_FULL_PCT 95
`define DAQ_ALMOST_EMPTY_PCT 5

// host bus
`define DAQ_ABUS_WIDTH 16

// data path widths
`define DAQ_HIT_WIDTH 16
`define DAQ_WORD_WIDTH 32

// fill count, read back as three bytes
`define DAQ_SIZE_WIDTH 24

`endif

//--- common/daq_pkg.sv
`include "daq_settings.svh"

package daq_pkg;

    // one detector hit
    typedef logic [`DAQ_HIT_WIDTH-1:0] hit_t;

    // packed pair, first hit in the low half
    typedef logic [`DAQ_WORD_WIDTH-1:0] word_t;

    // words held in the buffer
    typedef logic [`DAQ_SIZE_WIDTH-1:0] size_t;

    // host register map, byte wide
    // addresses 1 and 2 read the fill size but take thresholds on write
    typedef enum logic [7:0] {
        REG_SOFT_RST = 8'd0,
        REG_SIZE_LO  = 8'd1,    // write sets almost-full threshold
        REG_SIZE_MID = 8'd2,    // write sets almost-empty threshold
        REG_SIZE_HI  = 8'd3,
        REG_READ_ERR = 8'd4
    } reg_addr_e;

    // pairing state of the hit packer
    typedef enum logic {
        PK_EMPTY = 1'b0,        // nothing held
        PK_HALF  = 1'b1         // first hit of a pair held
    } packer_state_e;

endpackage

//--- common/word_link_if.sv
`timescale 1ns/1ps

// packer to buffer link, credit based
// the sender spends one credit per word, the receiver hands one back per pop
interface word_link_if;

    logic           word_valid;     // one word per cycle, never refused
    daq_pkg::word_t word_data;
    logic           credit_return;  // one pulse per popped word
    logic           link_clear;     // soft reset, drop pair and reload credits

    modport sender (
        output word_valid,
        output word_data,
        input  credit_return,
        input  link_clear
    );

    modport receiver (
        input  word_valid,
        input  word_data,
        output credit_return,
        output link_clear
    );

endinterface

//--- common/fifo_port_if.sv
`timescale 1ns/1ps

// buffer core to RAM FIFO
interface fifo_port_if;

    logic           write;      // ignored while full
    logic           read;       // ignored while empty
    daq_pkg::word_t data_in;
    daq_pkg::word_t data_out;   // head word, valid while not empty
    logic           full;
    logic           empty;
    daq_pkg::size_t size;

    // core side
    modport user (
        output write,
        output read,
        output data_in,
        input  data_out,
        input  full,
        input  empty,
        input  size
    );

    // RAM side
    modport fifo (
        input  write,
        input  read,
        input  data_in,
        output data_out,
        output full,
        output empty,
        output size
    );

endinterface

//--- bram_fifo/word_ram_fifo.sv
`timescale 1ns/1ps
`include "daq_settings.svh"

// RAM FIFO with first-word fall-through
// head word sits on data_out whenever the FIFO is not empty
module word_ram_fifo #(
    parameter int DEPTH = `DAQ_FIFO_DEPTH
) (
    input  logic      BUS_CLK,
    input  logic      RST,
    fifo_port_if.fifo port
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    daq_pkg::word_t mem [DEPTH];
    logic [AW-1:0]  wr_ptr;
    logic [AW-1:0]  rd_ptr;
    logic [AW:0]    count;     // occupancy, 0 to DEPTH
    logic           do_wr;
    logic           do_rd;

    assign port.full  = (count == (AW+1)'(DEPTH));
    assign port.empty = (count == '0);
    assign port.size  = daq_pkg::size_t'(count);

    assign do_wr = port.write && !port.full;   // overflow dropped
    assign do_rd = port.read && !port.empty;   // underflow dropped

    assign port.data_out = mem[rd_ptr];

    always_ff @(posedge BUS_CLK) begin
        if (do_wr) begin
            mem[wr_ptr] <= port.data_in;
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (RST) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                // explicit wrap keeps non power of two depths usable
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- bram_fifo/bram_fifo_core.sv
`timescale 1ns/1ps
`include "daq_settings.svh"

module bram_fifo_core #(
    parameter int DEPTH = `DAQ_FIFO_DEPTH
) (
    input  logic                       BUS_CLK,
    input  logic                       RST,
    input  logic [`DAQ_ABUS_WIDTH-1:0] bus_add,
    input  logic [7:0]                 bus_data_in,
    input  logic                       bus_rd,
    input  logic                       bus_wr,
    output logic [7:0]                 bus_data_out,
    input  logic                       bus_rd_data,
    output daq_pkg::word_t             bus_data_out_data,
    word_link_if.receiver              link,
    output logic                       fifo_near_full,
    output logic                       fifo_not_empty,
    output logic                       fifo_full,
    output logic                       fifo_read_error
);

    localparam logic [7:0] AF_RESET = 8'(255 * `DAQ_ALMOST_FULL_PCT / 100);
    localparam logic [7:0] AE_RESET = 8'(255 * `DAQ_ALMOST_EMPTY_PCT / 100);
    localparam int         PW       = `DAQ_SIZE_WIDTH + 2;

    fifo_port_if fifo_bus ();

    daq_pkg::reg_addr_e reg_sel;
    logic               reg_hit;    // address inside the byte-wide bank
    logic               soft_rst;
    logic               core_rst;
    logic [7:0]         af_thr;
    logic [7:0]         ae_thr;
    logic [7:0]         read_err;
    daq_pkg::size_t     af_level;
    daq_pkg::size_t     ae_level;
    logic               pop;

    // threshold byte to a word count, (thr+1)*depth/256
    function automatic daq_pkg::size_t thr_level(input logic [7:0] thr);
        logic [PW-1:0] prod;
        prod = PW'(thr) + 1'b1;
        prod = prod * PW'(DEPTH);
        return daq_pkg::size_t'(prod >> 8);
    endfunction

    assign reg_hit  = (bus_add[`DAQ_ABUS_WIDTH-1:8] == '0);
    assign reg_sel  = daq_pkg::reg_addr_e'(bus_add[7:0]);
    assign soft_rst = bus_wr && reg_hit && (reg_sel == daq_pkg::REG_SOFT_RST);
    assign core_rst = RST || soft_rst;

    assign link.link_clear = soft_rst;   // packer drops its pair in the same cycle

    word_ram_fifo #(
        .DEPTH (DEPTH)
    ) ram_fifo_i (
        .BUS_CLK (BUS_CLK),
        .RST     (core_rst),
        .port    (fifo_bus)
    );

    // every valid word is taken, credits keep the FIFO from overflowing
    assign fifo_bus.write   = link.word_valid;
    assign fifo_bus.data_in = link.word_data;
    assign fifo_bus.read    = bus_rd_data;

    assign pop = bus_rd_data && !fifo_bus.empty;

    // threshold bytes
    always_ff @(posedge BUS_CLK) begin
        if (core_rst) begin
            af_thr <= AF_RESET;
            ae_thr <= AE_RESET;
        end else if (bus_wr && reg_hit) begin
            if (reg_sel == daq_pkg::REG_SIZE_LO) begin
                af_thr <= bus_data_in;
            end
            if (reg_sel == daq_pkg::REG_SIZE_MID) begin
                ae_thr <= bus_data_in;
            end
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (bus_rd) begin
            bus_data_out <= 8'h00;  // unmapped reads give zero
            if (reg_hit) begin
                case (reg_sel)
                    daq_pkg::REG_SIZE_LO:  bus_data_out <= fifo_bus.size[7:0];
                    daq_pkg::REG_SIZE_MID: bus_data_out <= fifo_bus.size[15:8];
                    daq_pkg::REG_SIZE_HI:  bus_data_out <= fifo_bus.size[23:16];
                    daq_pkg::REG_READ_ERR: bus_data_out <= read_err;
                    default:               bus_data_out <= 8'h00;
                endcase
            end
        end
    end

    // data read path, head word captured as it is popped
    always_ff @(posedge BUS_CLK) begin
        if (pop) begin
            bus_data_out_data <= fifo_bus.data_out;
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (core_rst) begin
            link.credit_return <= 1'b0;
        end else begin
            link.credit_return <= pop;  // slot freed, same edge as the data
        end
    end

    // reads on an empty FIFO, saturating
    always_ff @(posedge BUS_CLK) begin
        if (core_rst) begin
            read_err <= 8'h00;
        end else if (bus_rd_data && fifo_bus.empty && (read_err != 8'hff)) begin
            read_err <= read_err + 1'b1;
        end
    end

    assign af_level = thr_level(af_thr);
    assign ae_level = thr_level(ae_thr);

    // near full with hysteresis, set wins over clear
    always_ff @(posedge BUS_CLK) begin
        if (core_rst) begin
            fifo_near_full <= 1'b0;
        end else if ((fifo_bus.size >= af_level) || (af_thr == 8'h00)) begin
            fifo_near_full <= 1'b1;
        end else if ((fifo_bus.size == '0)
                     || ((ae_thr != 8'h00) && (fifo_bus.size <= ae_level))) begin
            fifo_near_full <= 1'b0;
        end
    end

    assign fifo_not_empty  = !fifo_bus.empty;
    assign fifo_full       = fifo_bus.full;
    assign fifo_read_error = (read_err != 8'h00);

endmodule

//--- rtl/hit_packer.sv
`timescale 1ns/1ps
`include "daq_settings.svh"

module hit_packer #(
    parameter int DEPTH = `DAQ_FIFO_DEPTH     // credits after reset, one per slot
) (
    input  logic           BUS_CLK,
    input  logic           RST,
    input  logic           hit_valid,
    input  daq_pkg::hit_t  hit_data,
    output logic           hit_ready,
    word_link_if.sender    link
);

    localparam int CW = $clog2(DEPTH) + 1;

    daq_pkg::packer_state_e state;
    daq_pkg::hit_t          first_hit;  // low half of the pending word
    logic [CW-1:0]          credits;
    logic                   take;
    logic                   spend;

    // no credit, no hit, so a pending first hit can always be completed
    assign hit_ready = (credits != '0);
    assign take      = hit_valid && hit_ready;
    assign spend     = take && (state == daq_pkg::PK_HALF);  // second hit of a pair

    always_ff @(posedge BUS_CLK) begin
        if (RST || link.link_clear) begin
            state           <= daq_pkg::PK_EMPTY;  // half pair is dropped
            link.word_valid <= 1'b0;
        end else begin
            link.word_valid <= 1'b0;
            if (take) begin
                case (state)
                    daq_pkg::PK_EMPTY: begin
                        state <= daq_pkg::PK_HALF;
                    end
                    daq_pkg::PK_HALF: begin
                        state           <= daq_pkg::PK_EMPTY;
                        link.word_valid <= 1'b1;  // word out on the next cycle
                    end
                    default: begin
                        state <= daq_pkg::PK_EMPTY;
                    end
                endcase
            end
        end
    end

    // credit count, spend and return may coincide
    always_ff @(posedge BUS_CLK) begin
        if (RST || link.link_clear) begin
            credits <= CW'(DEPTH);
        end else begin
            case ({spend, link.credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (take && (state == daq_pkg::PK_EMPTY)) begin
            first_hit <= hit_data;
        end
        if (spend) begin
            link.word_data <= {hit_data, first_hit};  // second hit on top
        end
    end

endmodule

//--- rtl/daq_readout_top.sv
`timescale 1ns/1ps
`include "daq_settings.svh"

module daq_readout_top (
    input  logic                       BUS_CLK,
    input  logic                       RST,
    input  logic                       hit_valid,
    input  daq_pkg::hit_t              hit_data,
    output logic                       hit_ready,
    input  logic [`DAQ_ABUS_WIDTH-1:0] bus_add,
    input  logic [7:0]                 bus_data_in,
    input  logic                       bus_rd,
    input  logic                       bus_wr,
    output logic [7:0]                 bus_data_out,
    input  logic                       bus_rd_data,
    output daq_pkg::word_t             bus_data_out_data,
    output logic                       fifo_not_empty,
    output logic                       fifo_full,
    output logic                       fifo_near_full,
    output logic                       fifo_read_error
);

    word_link_if link_i ();  // packed words forward, credits back

    hit_packer #(
        .DEPTH (`DAQ_FIFO_DEPTH)
    ) packer_i (
        .BUS_CLK   (BUS_CLK),
        .RST       (RST),
        .hit_valid (hit_valid),
        .hit_data  (hit_data),
        .hit_ready (hit_ready),
        .link      (link_i)
    );

    // same depth on both sides so credits match the slots
    bram_fifo_core #(
        .DEPTH (`DAQ_FIFO_DEPTH)
    ) core_i (
        .BUS_CLK           (BUS_CLK),
        .RST               (RST),
        .bus_add           (bus_add),
        .bus_data_in       (bus_data_in),
        .bus_rd            (bus_rd),
        .bus_wr            (bus_wr),
        .bus_data_out      (bus_data_out),
        .bus_rd_data       (bus_rd_data),
        .bus_data_out_data (bus_data_out_data),
        .link              (link_i),
        .fifo_near_full    (fifo_near_full),
        .fifo_not_empty    (fifo_not_empty),
        .fifo_full         (fifo_full),
        .fifo_read_error   (fifo_read_error)
    );

endmodule

//--- bench/tb_daq_checks.svh
`ifndef TB_DAQ_CHECKS_SVH
`define TB_DAQ_CHECKS_SVH

// expected word, first hit in the low half
function automatic daq_pkg::word_t pack_ref(input daq_pkg::hit_t first,
                                            input daq_pkg::hit_t second);
    return {second, first};
endfunction

// galois lfsr, x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
endfunction

function automatic daq_pkg::hit_t next_hit();
    daq_pkg::hit_t h;
    for (int i = 0; i < 16; i++) begin
        h[i]       = lfsr_state[0];  // one step per bit
        lfsr_state = lfsr_step(lfsr_state);
    end
    return h;
endfunction

// near-full hysteresis, level = (thr+1)*depth/256
function automatic logic near_full_rule(input logic prev, input int size,
                                        input int af, input int ae);
    int af_lvl;
    int ae_lvl;
    af_lvl = ((af + 1) * DEPTH) / 256;
    ae_lvl = ((ae + 1) * DEPTH) / 256;
    if ((size >= af_lvl) || (af == 0))
        return 1'b1;
    if ((size == 0) || ((ae != 0) && (size <= ae_lvl)))
        return 1'b0;
    return prev;
endfunction

task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1, "stopped at first error");
endtask

task automatic check_word(input string name, input daq_pkg::word_t exp,
                          input daq_pkg::word_t act);
    if (act !== exp)
        fail_run($sformatf("[FAIL] %s expected %08h actual %08h", name, exp, act));
endtask

task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp)
        fail_run($sformatf("[FAIL] %s expected %02h actual %02h", name, exp, act));
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp)
        fail_run($sformatf("[FAIL] %s expected %b actual %b", name, exp, act));
endtask

task automatic settle();
    repeat (2) @(posedge BUS_CLK);  // word lands, then the flag follows
    #2;
endtask

task automatic write_reg(input daq_pkg::reg_addr_e addr, input logic [7:0] val);
    bus_add      = '0;
    bus_add[7:0] = addr;
    bus_data_in  = val;
    bus_wr       = 1'b1;
    @(posedge BUS_CLK);
    #2;
    bus_wr = 1'b0;
endtask

task automatic read_reg(input daq_pkg::reg_addr_e addr, output logic [7:0] val);
    bus_add      = '0;
    bus_add[7:0] = addr;
    bus_rd       = 1'b1;
    @(posedge BUS_CLK);
    #2;
    bus_rd = 1'b0;
    val    = bus_data_out;  // latched on the edge just passed
endtask

task automatic check_size(input string name);
    daq_pkg::size_t exp_size;
    logic [7:0]     b;
    exp_size = daq_pkg::size_t'(exp_q.size());
    for (int i = 0; i < 3; i++) begin
        read_reg(daq_pkg::reg_addr_e'(i + 1), b);
        check_byte($sformatf("%s size byte %0d", name, i), exp_size[8*i +: 8], b);
    end
endtask

// one pop, the compare process checks the word
task automatic read_word();
    bus_rd_data = 1'b1;
    @(posedge BUS_CLK);
    #2;
    bus_rd_data = 1'b0;
    @(posedge BUS_CLK);
    #2;
endtask

task automatic offer_hit(input daq_pkg::hit_t h, input int max_cycles, output logic taken);
    int n;
    taken     = 1'b0;
    n         = 0;
    hit_valid = 1'b1;
    hit_data  = h;
    while (!taken && (n < max_cycles)) begin
        taken = hit_ready;  // taken on the coming edge
        @(posedge BUS_CLK);
        #2;
        n++;
    end
    hit_valid = 1'b0;
endtask

task automatic model_take(input daq_pkg::hit_t h);
    if (pending_valid) begin
        exp_q.push_back(pack_ref(pending_hit, h));
        pending_valid = 1'b0;
    end else begin
        pending_hit   = h;
        pending_valid = 1'b1;
    end
endtask

task automatic send_hit(input daq_pkg::hit_t h);
    logic took;
    offer_hit(h, 20, took);
    if (!took)
        fail_run($sformatf("%s: hit %04h was never accepted by the packer", test_name, h));
    model_take(h);
endtask

task automatic update_near_full(input string name);
    nf_model = near_full_rule(nf_model, exp_q.size(), af_model, ae_model);
    check_flag($sformatf("%s near_full at size %0d", name, exp_q.size()),
               nf_model, fifo_near_full);
endtask

task automatic fill_words(input int n);
    repeat (n) begin
        send_hit(next_hit());
        send_hit(next_hit());
        settle();
        update_near_full(test_name);
    end
endtask

task automatic drain_one();
    check_flag({test_name, " not_empty before pop"}, 1'b1, fifo_not_empty);
    read_word();
    update_near_full(test_name);
endtask

task automatic empty_reads(input int n);
    repeat (n) begin
        read_word();
        if (err_model < 255)
            err_model++;  // saturates
    end
endtask

task automatic wait_ready(input int max_cycles);
    int n;
    n = 0;
    while (!hit_ready && (n < max_cycles)) begin
        @(posedge BUS_CLK);
        #2;
        n++;
    end
    if (!hit_ready)
        fail_run("hit_ready did not return after a word was popped");
endtask

`endif

//--- bench/tb_daq_readout.sv
`timescale 1ns/1ps
`include "daq_settings.svh"

module tb_daq_readout;

    localparam int DEPTH = `DAQ_FIFO_DEPTH;
    localparam int AF_DEFAULT = (255 * `DAQ_ALMOST_FULL_PCT) / 100;
    localparam int AE_DEFAULT = (255 * `DAQ_ALMOST_EMPTY_PCT) / 100;
    // cycles per test: reset, stream, back-pressure, read error, hysteresis, soft reset
    localparam int TEST_CYCLES = 20 + 60 + 100 + 540 + 120 + 180;
    localparam int WATCHDOG_NS = TEST_CYCLES * 20 + 2000;

    logic                       BUS_CLK;
    logic                       RST;
    logic                       hit_valid;
    daq_pkg::hit_t              hit_data;
    logic                       hit_ready;
    logic [`DAQ_ABUS_WIDTH-1:0] bus_add;
    logic [7:0]                 bus_data_in;
    logic                       bus_rd;
    logic                       bus_wr;
    logic [7:0]                 bus_data_out;
    logic                       bus_rd_data;
    daq_pkg::word_t             bus_data_out_data;
    logic                       fifo_not_empty;
    logic                       fifo_full;
    logic                       fifo_near_full;
    logic                       fifo_read_error;

    logic [15:0]    lfsr_state    = 16'd20;  // seed
    daq_pkg::word_t exp_q[$];                // written, not yet popped
    daq_pkg::hit_t  pending_hit;
    logic           pending_valid = 1'b0;
    daq_pkg::word_t cmp_exp;
    logic           cmp_armed     = 1'b0;
    int             words_checked = 0;
    int             err_model     = 0;
    int             af_model      = AF_DEFAULT;
    int             ae_model      = AE_DEFAULT;
    logic           nf_model      = 1'b0;
    string          test_name     = "reset";

    `include "tb_daq_checks.svh"

    daq_readout_top dut_i (.*);

    initial BUS_CLK = 1'b0;
    always #10 BUS_CLK = ~BUS_CLK;

    // inputs are quiet at the falling edge, a pop lands on the next rise
    always @(negedge BUS_CLK) begin
        if (cmp_armed) begin
            cmp_armed = 1'b0;
            check_word($sformatf("%s word %0d", test_name, words_checked),
                       cmp_exp, bus_data_out_data);
            words_checked++;
        end
        if (bus_rd_data && (exp_q.size() > 0)) begin
            cmp_exp   = exp_q.pop_front();
            cmp_armed = 1'b1;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the test sequence did not finish within %0d ns", WATCHDOG_NS);
        $display("TB FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        daq_pkg::hit_t h;
        logic          took;
        int            taken_hits;
        logic [7:0]    b;
        RST         = 1'b1;
        hit_valid   = 1'b0;
        hit_data    = '0;
        bus_add     = '0;
        bus_data_in = '0;
        bus_rd      = 1'b0;
        bus_wr      = 1'b0;
        bus_rd_data = 1'b0;
        repeat (3) @(posedge BUS_CLK);
        #2;
        RST = 1'b0;

        check_flag("reset hit_ready", 1'b1, hit_ready);
        check_flag("reset not_empty", 1'b0, fifo_not_empty);
        check_flag("reset full", 1'b0, fifo_full);
        check_flag("reset near_full", 1'b0, fifo_near_full);
        check_flag("reset read_error", 1'b0, fifo_read_error);
        for (int a = 1; a <= 4; a++) begin
            read_reg(daq_pkg::reg_addr_e'(a), b);
            check_byte($sformatf("reset reg %0d", a), 8'h00, b);
        end

        test_name = "stream";
        repeat (20) send_hit(next_hit());
        settle();
        check_size(test_name);
        repeat (10) drain_one();
        check_flag("stream drained", 1'b0, fifo_not_empty);

        test_name  = "backpressure";
        taken_hits = 0;
        do begin
            h = next_hit();
            offer_hit(h, 4, took);  // four idle cycles means credits are gone
            if (took) begin
                model_take(h);
                taken_hits++;
            end
        end while (took);
        if (taken_hits != 2 * DEPTH)
            fail_run($sformatf("[FAIL] backpressure hits taken expected %0d actual %0d",
                               2 * DEPTH, taken_hits));
        settle();
        check_flag("backpressure full", 1'b1, fifo_full);
        check_flag("backpressure hit_ready", 1'b0, hit_ready);
        check_size(test_name);
        drain_one();
        wait_ready(8);
        repeat (DEPTH - 1) drain_one();

        test_name = "read_error";
        empty_reads(3);
        check_flag("read_error flag", 1'b1, fifo_read_error);
        read_reg(daq_pkg::REG_READ_ERR, b);
        check_byte("read_error count", 8'(err_model), b);
        empty_reads(257);
        read_reg(daq_pkg::REG_READ_ERR, b);
        check_byte("read_error saturated", 8'(err_model), b);

        test_name = "hysteresis";
        af_model  = 191;  // sets at 12 words
        ae_model  = 63;   // clears at 4 words
        write_reg(daq_pkg::REG_SIZE_LO, 8'(af_model));
        write_reg(daq_pkg::REG_SIZE_MID, 8'(ae_model));
        fill_words(DEPTH);
        repeat (DEPTH) drain_one();

        test_name = "soft_reset";
        fill_words(13);
        send_hit(next_hit());  // half pair left in the packer
        write_reg(daq_pkg::REG_SOFT_RST, 8'h00);
        exp_q.delete();
        pending_valid = 1'b0;
        err_model     = 0;
        af_model      = AF_DEFAULT;
        ae_model      = AE_DEFAULT;
        nf_model      = 1'b0;
        check_flag("soft_reset near_full", 1'b0, fifo_near_full);
        check_flag("soft_reset not_empty", 1'b0, fifo_not_empty);
        check_flag("soft_reset full", 1'b0, fifo_full);
        check_flag("soft_reset read_error", 1'b0, fifo_read_error);
        check_flag("soft_reset hit_ready", 1'b1, hit_ready);
        read_reg(daq_pkg::REG_READ_ERR, b);
        check_byte("soft_reset error count", 8'(err_model), b);
        check_size(test_name);
        fill_words(DEPTH - 1);  // default thresholds only set at 15
        repeat (DEPTH - 1) drain_one();

        $display("TB PASSED");
        $finish;
    end

endmodule

//--- daq_fifo.f
+incdir+common
+incdir+bench
common/daq_pkg.sv
common/word_link_if.sv
common/fifo_port_if.sv
bram_fifo/word_ram_fifo.sv
bram_fifo/bram_fifo_core.sv
rtl/hit_packer.sv
rtl/daq_readout_top.sv
bench/tb_daq_readout.sv

//--- run_sim.sh
#!/bin/sh
# build and run the daq_fifo testbench with Verilator
cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_daq_readout \
    -f daq_fifo.f -Mdir obj_dir -o tb_daq_readout > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    echo "verilator build failed, see $BUILD_LOG"
    exit 1
fi

./obj_dir/tb_daq_readout > "$SIM_LOG" 2>&1
if [ $? -ne 0 ]; then
    echo "simulation returned an error status, see $SIM_LOG"
    exit 1
fi

if grep -qx "TB PASSED" "$SIM_LOG"; then
    echo "result: pass"
    exit 0
fi
echo "result: fail, see $SIM_LOG"
exit 1
